/* testbench/mycpu_patterns.hex */
// header: program word count, trace record count
// then program words from the reset pc, then records of pc, rf_wnum, rf_wdata
00000022 00000016
// alu register, immediate and shift forms
029ffc01 02bffc02 15000003 00100824
00110825 00120446 00128447 00140028
00148829 0015046a 0015886b 0040fc2c
0044906d 0048906e 0012086f
// store, load and the write to r0
2981000a 28810010 02848c00 00104011
// beq and bne both ways, then b. skipped words write r18
58000a0a 02800412 5c000a0a 5c000822
02800812 58000822 50000800 02800c12
// bl, jirl and the final self loop
54000c00 02801413 50001000 02800034
4c000035 02801012 50000000
// expected trace
1c000000 01 000007ff
1c000004 02 ffffffff
1c000008 03 80000000
1c00000c 04 000007fe
1c000010 05 00000800
1c000014 06 00000001
1c000018 07 00000000
1c00001c 08 fffff800
1c000020 09 000007ff
1c000024 0a 800007ff
1c000028 0b 7fffffff
1c00002c 0c 80000000
1c000030 0d 08000000
1c000034 0e f8000000
1c000038 0f 00000001
1c000040 10 800007ff
1c000044 00 00000123
1c000048 11 800007ff
1c00006c 01 1c000070
1c000078 14 1c000070
1c00007c 15 1c000080
1c000070 13 00000005

/* vlog.f */
rtl/la32_isa_pkg.sv
rtl/core_bus_pkg.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/regfile.sv
rtl/multicycle_ctrl.sv
rtl/mycpu_top.sv
testbench/mycpu_assert.sv
testbench/tb_mycpu.sv

/* testbench/tb_mycpu.sv */
`timescale 1ns/100ps

module tb_mycpu;
    import core_bus_pkg::*;

    localparam logic [31:0] RESET_PC   = 32'h1c000000;
    localparam int          PAT_WORDS  = 256;
    localparam int          IMEM_WORDS = 256;
    localparam int          DMEM_WORDS = 1024;
    localparam string       PAT_FILE   = "testbench/mycpu_patterns.hex";

    logic         clk;
    logic         reset;
    wb_req_t      ibus_req;
    wb_rsp_t      ibus_rsp;
    wb_req_t      dbus_req;
    wb_rsp_t      dbus_rsp;
    debug_trace_t debug_trace;

    logic [31:0] pattern_mem [PAT_WORDS];
    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];

    int unsigned num_prog;
    int unsigned num_rec;
    int unsigned rec_idx;
    logic [31:0] loop_pc;
    logic        patterns_loaded;
    logic        loop_reached;
    logic        fetch_seen;

    logic [31:0] lfsr;
    logic        ibus_busy;
    logic        dbus_busy;
    int unsigned ibus_wait;
    int unsigned dbus_wait;

    mycpu_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .dbus_req    (dbus_req),
        .dbus_rsp    (dbus_rsp),
        .debug_trace (debug_trace)
    );

    bind mycpu_top mycpu_assert u_assert (
        .clk         (clk),
        .reset       (reset),
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .dbus_req    (dbus_req),
        .dbus_rsp    (dbus_rsp),
        .debug_trace (debug_trace),
        .rf_we       (rf_we),
        .rf_waddr    (dec.dest)
    );

    always #5 clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================
    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_wait(output int unsigned count);
        count = 0;
        repeat (2) begin
            lfsr  = lfsr_next(lfsr);
            count = (count << 1) | lfsr[0];
        end
    endtask

    // ==================================================
    // memory models
    // ==================================================
    task automatic serve_ibus();
        logic [31:0] offs;
        if (reset || !ibus_req.stb) begin
            ibus_rsp.ack = 1'b0;
            ibus_busy    = 1'b0;
        end else begin
            ibus_rsp.ack = 1'b0;
            if (!ibus_busy) begin               // new cycle.
                ibus_busy = 1'b1;
                draw_wait(ibus_wait);
                if (!fetch_seen) check_value("ibus_req.adr", ibus_req.adr, RESET_PC);
                fetch_seen = 1'b1;
            end
            if (ibus_wait == 0) begin
                offs = ibus_req.adr - RESET_PC;
                if (ibus_req.adr < RESET_PC || offs[1:0] != 2'b0 || (offs >> 2) >= num_prog) begin
                    $display("instruction fetch outside the program at %h", ibus_req.adr);
                    stop_with_failure();
                end
                ibus_rsp.dat = imem[offs >> 2];
                ibus_rsp.ack = 1'b1;
                ibus_busy    = 1'b0;
            end else begin
                ibus_wait--;
            end
        end
    endtask

    task automatic serve_dbus();
        int unsigned idx;
        if (reset || !dbus_req.stb) begin
            dbus_rsp.ack = 1'b0;
            dbus_busy    = 1'b0;
        end else begin
            dbus_rsp.ack = 1'b0;
            if (!dbus_busy) begin
                dbus_busy = 1'b1;
                draw_wait(dbus_wait);
            end
            if (dbus_wait == 0) begin
                if (dbus_req.adr[31:12] != 20'b0) begin
                    $display("data access outside memory at %h", dbus_req.adr);
                    stop_with_failure();
                end
                idx = dbus_req.adr[11:2];
                if (dbus_req.we) dmem[idx] = dbus_req.dat;
                else dbus_rsp.dat = dmem[idx];
                dbus_rsp.ack = 1'b1;
                dbus_busy    = 1'b0;
            end else begin
                dbus_wait--;
            end
        end
    endtask

    // one block for both buses keeps the lfsr draw order fixed.
    always @(posedge clk) begin
        #1;
        serve_ibus();
        serve_dbus();
    end

    // ==================================================
    // trace checking
    // ==================================================
    task automatic compare_trace();
        int unsigned base;
        if (rec_idx >= num_rec) begin
            $display("unexpected register write at pc %h after the last record", debug_trace.pc);
            stop_with_failure();
        end else begin
            base = 2 + num_prog + 3 * rec_idx;
            check_value("debug_trace.pc", debug_trace.pc, pattern_mem[base]);
            check_value("debug_trace.rf_wnum", {27'b0, debug_trace.rf_wnum}, pattern_mem[base + 1]);
            check_value("debug_trace.rf_wdata", debug_trace.rf_wdata, pattern_mem[base + 2]);
            rec_idx++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && patterns_loaded) begin
            if (debug_trace.rf_we) compare_trace();
            if (debug_trace.pc == loop_pc) loop_reached = 1'b1;
        end
    end

    task automatic load_patterns();
        $readmemh(PAT_FILE, pattern_mem);
        if ($isunknown(pattern_mem[0]) || $isunknown(pattern_mem[1])) begin
            $display("pattern file %s is missing or has no header", PAT_FILE);
            stop_with_failure();
        end
        num_prog = pattern_mem[0];
        num_rec  = pattern_mem[1];
        if (num_prog == 0 || num_prog > IMEM_WORDS || 2 + num_prog + 3 * num_rec > PAT_WORDS) begin
            $display("pattern file header gives counts out of range");
            stop_with_failure();
        end
        for (int i = 0; i < num_prog; i++) imem[i] = pattern_mem[2 + i];
        loop_pc = RESET_PC + 4 * (num_prog - 1);    // last word is the self loop.
    endtask

    // ==================================================
    // main sequence and watchdog
    // ==================================================
    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        ibus_rsp        = '0;
        dbus_rsp        = '0;
        lfsr            = 32'hf591;
        ibus_busy       = 1'b0;
        dbus_busy       = 1'b0;
        ibus_wait       = 0;
        dbus_wait       = 0;
        rec_idx         = 0;
        fetch_seen      = 1'b0;
        loop_reached    = 1'b0;
        patterns_loaded = 1'b0;
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = 32'b0;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = 32'b0;
        load_patterns();
        patterns_loaded = 1'b1;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        wait (loop_reached);
        if (rec_idx == num_rec) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("final loop reached with %0d of %0d records seen", rec_idx, num_rec);
            stop_with_failure();
        end
    end

    initial begin : watchdog
        wait (patterns_loaded);
        repeat (num_rec * 40) @(posedge clk);
        $display("timeout after %0d cycles, the final loop was never reached", num_rec * 40);
        stop_with_failure();
    end

endmodule

/* testbench/mycpu_assert.sv */
`timescale 1ns/100ps

module mycpu_assert (
    input logic                       clk,
    input logic                       reset,
    input core_bus_pkg::wb_req_t      ibus_req,
    input core_bus_pkg::wb_rsp_t      ibus_rsp,
    input core_bus_pkg::wb_req_t      dbus_req,
    input core_bus_pkg::wb_rsp_t      dbus_rsp,
    input core_bus_pkg::debug_trace_t debug_trace,
    input logic                       rf_we,
    input logic [4:0]                 rf_waddr
);

    // ==================================================
    // wishbone classic
    // ==================================================
    ibus_stb_cyc: assert property (@(posedge clk) disable iff (reset)
        ibus_req.stb |-> ibus_req.cyc) else $error("ibus stb without cyc");
    dbus_stb_cyc: assert property (@(posedge clk) disable iff (reset)
        dbus_req.stb |-> dbus_req.cyc) else $error("dbus stb without cyc");

    // request held until ack.
    ibus_hold: assert property (@(posedge clk) disable iff (reset)
        ibus_req.stb && !ibus_rsp.ack |=> ibus_req.stb && $stable(ibus_req))
        else $error("ibus request changed before ack");
    dbus_hold: assert property (@(posedge clk) disable iff (reset)
        dbus_req.stb && !dbus_rsp.ack |=> dbus_req.stb && $stable(dbus_req))
        else $error("dbus request changed before ack");

    ibus_no_write: assert property (@(posedge clk) disable iff (reset)
        !ibus_req.we) else $error("ibus write");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !ibus_req.cyc && !dbus_req.cyc && !debug_trace.rf_we)
        else $error("bus or register write active during reset");

    // ==================================================
    // trace port and register file
    // ==================================================
    trace_matches_write: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> debug_trace.rf_we && debug_trace.rf_wnum == rf_waddr)
        else $error("trace does not match the register write");
    write_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rf_we |=> !rf_we) else $error("rf_we held longer than one cycle");

endmodule

/* rtl/mycpu_top.sv */
`timescale 1ns/100ps

module mycpu_top #(
    parameter logic [31:0] RESET_PC = 32'h1c000000
) (
    input  logic                       clk,
    input  logic                       reset,
    output core_bus_pkg::wb_req_t      ibus_req,
    input  core_bus_pkg::wb_rsp_t      ibus_rsp,
    output core_bus_pkg::wb_req_t      dbus_req,
    input  core_bus_pkg::wb_rsp_t      dbus_rsp,
    output core_bus_pkg::debug_trace_t debug_trace
);
    import la32_isa_pkg::*;

    decoded_inst_t dec;

    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic [31:0] result_q;
    logic        decode_cycle;

    logic        ibus_stb;
    logic        dbus_stb;
    logic        ir_load;
    logic        pc_load;
    logic        res_load;
    logic        rf_we;

    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic        rj_eq_rd;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] seq_pc;

    inst_decoder u_decoder (
        .inst (ir),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .rdata1 (rf_rdata1),
        .raddr2 (dec.rk_or_rd),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dec.dest),
        .wdata  (result_q)
    );

    multicycle_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec),
        .br_taken (br_taken),
        .ibus_ack (ibus_rsp.ack),
        .dbus_ack (dbus_rsp.ack),
        .ibus_stb (ibus_stb),
        .dbus_stb (dbus_stb),
        .ir_load  (ir_load),
        .pc_load  (pc_load),
        .res_load (res_load),
        .rf_we    (rf_we)
    );

    // ==================================================
    // pc, branch resolution
    // ==================================================
    assign rj_eq_rd  = (rf_rdata1 == rf_rdata2);
    assign br_taken  = dec.is_branch &&
                       ((dec.op != op_beq && dec.op != op_bne) ||
                        ((dec.op == op_beq) == rj_eq_rd));
    assign br_target = dec.is_jirl ? (opnd_a + dec.br_offs) : (pc + dec.br_offs);
    assign seq_pc    = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= RESET_PC;
            decode_cycle <= 1'b0;
        end else begin
            if (pc_load) pc <= br_taken ? br_target : seq_pc;
            decode_cycle <= ir_load;    // decode always follows the fetch ack.
        end
    end

    // ==================================================
    // instruction, operand and result registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (ir_load) ir <= ibus_rsp.dat;
        if (decode_cycle) begin
            opnd_a <= rf_rdata1;
            opnd_b <= rf_rdata2;
        end
        // load data lands here on dbus ack, the alu result otherwise.
        if (res_load) result_q <= dbus_stb ? dbus_rsp.dat : alu_result;
    end

    assign alu_src1 = dec.src1_is_pc  ? pc     : opnd_a;
    assign alu_src2 = dec.src2_is_4   ? 32'd4  :
                      dec.src2_is_imm ? dec.imm : opnd_b;

    alu u_alu (
        .alu_op (dec.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // ==================================================
    // bus and trace drivers
    // ==================================================
    assign ibus_req.cyc = ibus_stb;
    assign ibus_req.stb = ibus_stb;
    assign ibus_req.we  = 1'b0;
    assign ibus_req.adr = pc;
    assign ibus_req.dat = 32'b0;

    assign dbus_req.cyc = dbus_stb;
    assign dbus_req.stb = dbus_stb;
    assign dbus_req.we  = dec.mem_we;
    assign dbus_req.adr = result_q;     // effective address from execute.
    assign dbus_req.dat = opnd_b;

    assign debug_trace.pc       = pc;
    assign debug_trace.rf_we    = rf_we;
    assign debug_trace.rf_wnum  = dec.dest;
    assign debug_trace.rf_wdata = result_q;

endmodule

/* rtl/multicycle_ctrl.sv */
`timescale 1ns/100ps

module multicycle_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  la32_isa_pkg::decoded_inst_t dec,
    input  logic                        br_taken,
    input  logic                        ibus_ack,
    input  logic                        dbus_ack,
    output logic                        ibus_stb,
    output logic                        dbus_stb,
    output logic                        ir_load,
    output logic                        pc_load,
    output logic                        res_load,
    output logic                        rf_we
);

    typedef enum logic [2:0] {
        s_fetch     = 3'd0,
        s_decode    = 3'd1,
        s_execute   = 3'd2,
        s_memory    = 3'd3,
        s_writeback = 3'd4
    } state_e;

    state_e state;
    state_e next_state;
    logic   ifetch_done;
    logic   mem_done;
    logic   done_in_decode;

    assign ifetch_done = ibus_stb && ibus_ack;
    assign mem_done    = dbus_stb && dbus_ack;

    // a linking jump defers its pc update to writeback.
    assign done_in_decode = dec.is_branch && !(br_taken && dec.gr_we);

    // ==================================================
    // state sequencing
    // ==================================================
    always_comb begin
        next_state = state;
        unique case (state)
            s_fetch:     if (ifetch_done) next_state = s_decode;
            s_decode:    next_state = done_in_decode ? s_fetch : s_execute;
            s_execute: begin
                if (dec.res_from_mem || dec.mem_we) next_state = s_memory;
                else next_state = s_writeback;
            end
            s_memory: begin
                if (mem_done) next_state = dec.res_from_mem ? s_writeback : s_fetch;
            end
            s_writeback: next_state = s_fetch;
            default:     next_state = s_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_fetch;
            ibus_stb <= 1'b0;
            dbus_stb <= 1'b0;
        end else begin
            state    <= next_state;
            ibus_stb <= (next_state == s_fetch);     // held until ack.
            dbus_stb <= (next_state == s_memory);
        end
    end

    // ==================================================
    // load enables
    // ==================================================
    assign ir_load  = (state == s_fetch) && ifetch_done;
    assign res_load = (state == s_execute) ||
                      ((state == s_memory) && mem_done && dec.res_from_mem);
    assign pc_load  = ((state == s_decode) && done_in_decode) ||
                      ((state == s_memory) && mem_done && dec.mem_we) ||
                      (state == s_writeback);
    assign rf_we    = (state == s_writeback) && dec.gr_we;

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero.
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : rf[raddr2];

endmodule

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu (
    input  la32_isa_pkg::alu_op_e alu_op,
    input  logic [31:0]           src1,
    input  logic [31:0]           src2,
    output logic [31:0]           result
);
    import la32_isa_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;

    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    always_comb begin
        unique case (alu_op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'b0, src1 < src2};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $unsigned($signed(src1) >>> shamt);
            alu_lui:  result = src2;        // immediate is already shifted.
            default:  result = sum;
        endcase
    end

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  logic [31:0]                inst,
    output la32_isa_pkg::decoded_inst_t dec
);
    import la32_isa_pkg::*;

    inst_op_e    op;
    logic [31:0] ui5;
    logic [31:0] si12;
    logic [31:0] si16;
    logic [31:0] si20;
    logic [31:0] si26;

    assign ui5  = {27'b0, inst[14:10]};
    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign si16 = {{14{inst[25]}}, inst[25:10], 2'b0};     // word offset.
    assign si20 = {inst[24:5], 12'b0};
    assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    // ==================================================
    // opcode match
    // ==================================================
    always_comb begin
        op = op_invalid;
        unique case (inst[31:26])
            6'h00: begin
                if (inst[25:22] == 4'h0 && inst[21:20] == 2'h1) begin
                    case (inst[19:15])
                        5'h00:   op = op_add_w;
                        5'h02:   op = op_sub_w;
                        5'h04:   op = op_slt;
                        5'h05:   op = op_sltu;
                        5'h08:   op = op_nor;
                        5'h09:   op = op_and;
                        5'h0a:   op = op_or;
                        5'h0b:   op = op_xor;
                        default: op = op_invalid;
                    endcase
                end else if (inst[25:22] == 4'h1 && inst[21:20] == 2'h0) begin
                    case (inst[19:15])
                        5'h01:   op = op_slli_w;
                        5'h09:   op = op_srli_w;
                        5'h11:   op = op_srai_w;
                        default: op = op_invalid;
                    endcase
                end else if (inst[25:22] == 4'ha) begin
                    op = op_addi_w;
                end
            end
            6'h05: if (!inst[25]) op = op_lu12i_w;
            6'h0a: begin
                if (inst[25:22] == 4'h2) op = op_ld_w;
                else if (inst[25:22] == 4'h6) op = op_st_w;
            end
            6'h13: op = op_jirl;
            6'h14: op = op_b;
            6'h15: op = op_bl;
            6'h16: op = op_beq;
            6'h17: op = op_bne;
            default: op = op_invalid;
        endcase
    end

    // ==================================================
    // control fields
    // ==================================================
    always_comb begin
        dec              = '0;
        dec.op           = op;
        dec.alu_op       = alu_add;
        dec.rj           = inst[9:5];
        dec.rk_or_rd     = inst[14:10];
        dec.dest         = inst[4:0];
        dec.br_offs      = (op == op_b || op == op_bl) ? si26 : si16;
        unique case (op)
            op_add_w, op_sub_w, op_slt, op_sltu,
            op_nor, op_and, op_or, op_xor: begin
                dec.gr_we = 1'b1;
                case (op)
                    op_sub_w: dec.alu_op = alu_sub;
                    op_slt:   dec.alu_op = alu_slt;
                    op_sltu:  dec.alu_op = alu_sltu;
                    op_nor:   dec.alu_op = alu_nor;
                    op_and:   dec.alu_op = alu_and;
                    op_or:    dec.alu_op = alu_or;
                    op_xor:   dec.alu_op = alu_xor;
                    default:  dec.alu_op = alu_add;
                endcase
            end
            op_slli_w, op_srli_w, op_srai_w: begin
                dec.gr_we       = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = ui5;
                dec.alu_op      = (op == op_slli_w) ? alu_sll :
                                  (op == op_srli_w) ? alu_srl : alu_sra;
            end
            op_addi_w, op_ld_w: begin
                dec.gr_we        = 1'b1;
                dec.src2_is_imm  = 1'b1;
                dec.imm          = si12;
                dec.res_from_mem = (op == op_ld_w);
            end
            op_st_w: begin
                dec.src2_is_imm = 1'b1;
                dec.imm         = si12;
                dec.mem_we      = 1'b1;
                dec.rk_or_rd    = inst[4:0];
            end
            op_jirl, op_bl: begin
                dec.gr_we      = 1'b1;
                dec.src1_is_pc = 1'b1;      // link value is pc + 4.
                dec.src2_is_4  = 1'b1;
                dec.is_branch  = 1'b1;
                dec.is_jirl    = (op == op_jirl);
                dec.imm        = dec.br_offs;
                if (op == op_bl) dec.dest = 5'd1;
            end
            op_b: dec.is_branch = 1'b1;
            op_beq, op_bne: begin
                dec.is_branch = 1'b1;
                dec.rk_or_rd  = inst[4:0];
            end
            op_lu12i_w: begin
                dec.gr_we       = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = si20;
                dec.alu_op      = alu_lui;
            end
            default: dec.dest = inst[4:0];  // invalid, no side effects.
        endcase
    end

endmodule

/* rtl/core_bus_pkg.sv */
package core_bus_pkg;

    // ==================================================
    // wishbone classic, word access only
    // ==================================================
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // ==================================================
    // register write trace
    // ==================================================
    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
    } debug_trace_t;

endpackage

/* rtl/la32_isa_pkg.sv */
package la32_isa_pkg;

    // ==================================================
    // instructions and alu operations
    // ==================================================
    typedef enum logic [4:0] {
        op_invalid = 5'd0,
        op_add_w   = 5'd1,
        op_sub_w   = 5'd2,
        op_slt     = 5'd3,
        op_sltu    = 5'd4,
        op_nor     = 5'd5,
        op_and     = 5'd6,
        op_or      = 5'd7,
        op_xor     = 5'd8,
        op_slli_w  = 5'd9,
        op_srli_w  = 5'd10,
        op_srai_w  = 5'd11,
        op_addi_w  = 5'd12,
        op_ld_w    = 5'd13,
        op_st_w    = 5'd14,
        op_jirl    = 5'd15,
        op_b       = 5'd16,
        op_bl      = 5'd17,
        op_beq     = 5'd18,
        op_bne     = 5'd19,
        op_lu12i_w = 5'd20
    } inst_op_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

    // ==================================================
    // decoder output
    // ==================================================
    typedef struct packed {
        inst_op_e    op;
        alu_op_e     alu_op;
        logic [4:0]  rj;
        logic [4:0]  rk_or_rd;       // second source, rd for st.w/beq/bne.
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [31:0] br_offs;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_4;
        logic        gr_we;
        logic        mem_we;
        logic        res_from_mem;
        logic        is_branch;      // b, bl, beq, bne and jirl.
        logic        is_jirl;
    } decoded_inst_t;

endpackage
